// File: Makefile
VERILATOR ?= verilator
TOP       ?= vld_tb
FILELIST  ?= vld.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/obi_if.sv
`timescale 1ns/10ps

interface obi_if
    import vld_pkg::*;
();

    // Address phase
    logic               req;
    logic               gnt;
    AddrT               addr;
    IdT                 aid;
    logic               we;
    logic [BeWidth-1:0] be;
    VectorT             wdata;

    // Read phase
    logic               rvalid;
    logic               rready;
    IdT                 rid;
    VectorT             rdata;

    modport mst (
        output req, addr, aid, we, be, wdata, rready,
        input  gnt, rvalid, rid, rdata
    );

    modport slv (
        input  req, addr, aid, we, be, wdata, rready,
        output gnt, rvalid, rid, rdata
    );

endinterface

// File: design/vld_decode.sv
`timescale 1ns/10ps

module vld_decode
    import vld_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic insn_valid,
    output logic insn_ready,
    input  InsnT insn,
    input  AddrT insn_rs1,
    output logic insn_err,
    xadac_if.mst xadac,
    output logic alloc_valid,
    output IdT   alloc_id,
    output VregT alloc_vd,
    input  logic retire_valid,
    input  IdT   retire_id
);

    logic [NoIds-1:0] busy_q;
    logic [NoIds-1:0] busy_d;
    IdT               free_id;
    ImmT              imm;
    VregT             vd;
    logic             legal;
    logic             accept;
    logic             issue;

    assign imm = insn[ImmLsb +: ImmWidth];
    assign vd  = insn[VdLsb +: VregWidth];

    assign legal = (insn[OpcodeLsb +: OpcodeWidth] == OpcodeVld) &&
                   (insn[FunctLsb +: FunctWidth] == '0) &&
                   (imm != '0) && (imm <= ImmT'(NoElems));

    // Stall while every ID is in flight or the last request is not taken yet
    assign insn_ready = !(&busy_q) && !xadac.req_valid;
    assign accept     = insn_valid && insn_ready;
    assign issue      = accept && legal;

    // Lowest free ID
    always_comb begin
        free_id = '0;
        for (int i = NoIds - 1; i >= 0; i--) begin
            if (!busy_q[i]) free_id = IdT'(i);
        end
    end

    always_comb begin
        busy_d = busy_q;
        if (retire_valid) busy_d[retire_id] = 1'b0;
        if (issue) busy_d[free_id] = 1'b1;
    end

    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) begin
            busy_q          <= '0;
            insn_err        <= 1'b0;
            alloc_valid     <= 1'b0;
            xadac.req_valid <= 1'b0;
        end else begin
            busy_q      <= busy_d;
            insn_err    <= accept && !legal;
            alloc_valid <= issue;
            if (issue) begin
                xadac.req_valid <= 1'b1;
            end else if (xadac.req_valid && xadac.req_ready) begin
                xadac.req_valid <= 1'b0;
            end
        end
    end

    // Request and allocation payload
    always_ff @(posedge clk) begin
        if (issue) begin
            xadac.req_id  <= free_id;
            xadac.req_rs1 <= insn_rs1;
            xadac.req_imm <= imm;
            alloc_id      <= free_id;
            alloc_vd      <= vd;
        end
    end

    // Retirement comes back from the reorder stage
    a_retire_busy: assert property (
        @(posedge clk) disable iff (!rstn) retire_valid |-> busy_q[retire_id]
    ) else $error("retired ID %0d was not busy", retire_id);

endmodule

// File: design/vld_pkg.sv
package vld_pkg;

    // Transaction IDs
    localparam int unsigned IdWidth = 2;
    localparam int unsigned NoIds   = 2**IdWidth;
    typedef logic [IdWidth-1:0] IdT;

    // Byte addresses
    localparam int unsigned AddrWidth = 32;
    typedef logic [AddrWidth-1:0] AddrT;

    // One memory word holds one full vector
    localparam int unsigned VectorWidth = 128;
    localparam int unsigned ElemWidth   = 16;
    localparam int unsigned NoElems     = VectorWidth / ElemWidth;
    localparam int unsigned BeWidth     = VectorWidth / 8;
    typedef logic [VectorWidth-1:0] VectorT;

    // Replication period, legal range 1 to NoElems
    localparam int unsigned ImmWidth = 4;
    typedef logic [ImmWidth-1:0] ImmT;

    localparam int unsigned VregWidth = 5;
    typedef logic [VregWidth-1:0] VregT;

    typedef logic [31:0] InsnT;

    // Instruction layout
    localparam int unsigned OpcodeLsb   = 0;
    localparam int unsigned OpcodeWidth = 7;
    localparam int unsigned VdLsb       = 7;
    localparam int unsigned FunctLsb    = 12;
    localparam int unsigned FunctWidth  = 3;
    localparam int unsigned ImmLsb      = 20;

    // Custom-0 major opcode
    localparam logic [OpcodeWidth-1:0] OpcodeVld = 7'b0001011;

endpackage

// File: design/vld_reorder.sv
`timescale 1ns/10ps

module vld_reorder
    import vld_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    xadac_if.mst   xadac,
    input  logic   alloc_valid,
    input  IdT     alloc_id,
    input  VregT   alloc_vd,
    output logic   retire_valid,
    output IdT     retire_id,
    output logic   wb_valid,
    input  logic   wb_ready,
    output VregT   wb_vd,
    output VectorT wb_data
);

    // Issue order FIFO of IDs
    IdT               order_q [NoIds];
    IdT               head_q;
    IdT               tail_q;

    // Per-ID result table
    VregT             vd_q    [NoIds];
    VectorT           data_q  [NoIds];
    logic [NoIds-1:0] pend_q;
    logic [NoIds-1:0] arrived_q;

    IdT               head_id;
    logic             resp_fire;
    logic             pop;

    // Every response has its own slot, so never back-pressure
    assign xadac.resp_ready = 1'b1;
    assign resp_fire        = xadac.resp_valid && xadac.resp_ready;

    assign head_id  = order_q[head_q];
    assign wb_valid = (|pend_q) && arrived_q[head_id];
    assign wb_vd    = vd_q[head_id];
    assign wb_data  = data_q[head_id];
    assign pop      = wb_valid && wb_ready;

    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) begin
            head_q       <= '0;
            tail_q       <= '0;
            pend_q       <= '0;
            arrived_q    <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
            if (pop) begin
                head_q             <= head_q + 1'b1;
                pend_q[head_id]    <= 1'b0;
                arrived_q[head_id] <= 1'b0;
            end
            if (resp_fire) arrived_q[xadac.resp_id] <= 1'b1;
            if (alloc_valid) begin
                tail_q              <= tail_q + 1'b1;
                pend_q[alloc_id]    <= 1'b1;
                arrived_q[alloc_id] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            order_q[tail_q] <= alloc_id;
            vd_q[alloc_id]  <= alloc_vd;
        end
        if (resp_fire) data_q[xadac.resp_id] <= xadac.resp_vd;
        if (pop) retire_id <= head_id;
    end

    // The load unit may only answer IDs that decode handed out
    a_resp_allocated: assert property (
        @(posedge clk) disable iff (!rstn)
        xadac.resp_valid |-> pend_q[xadac.resp_id] && !arrived_q[xadac.resp_id]
    ) else $error("response for ID %0d not allocated", xadac.resp_id);

endmodule

// File: design/vld_top.sv
`timescale 1ns/10ps

module vld_top
    import vld_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   insn_valid,
    output logic   insn_ready,
    input  InsnT   insn,
    input  AddrT   insn_rs1,
    output logic   insn_err,
    output logic   obi_req,
    input  logic   obi_gnt,
    output AddrT   obi_addr,
    output IdT     obi_aid,
    input  logic   obi_rvalid,
    input  IdT     obi_rid,
    input  VectorT obi_rdata,
    output logic   wb_valid,
    input  logic   wb_ready,
    output VregT   wb_vd,
    output VectorT wb_data
);

    xadac_if xadac_bus ();
    obi_if   obi_bus ();

    logic alloc_valid;
    IdT   alloc_id;
    VregT alloc_vd;
    logic retire_valid;
    IdT   retire_id;

    // OBI master pins
    assign obi_req        = obi_bus.req;
    assign obi_addr       = obi_bus.addr;
    assign obi_aid        = obi_bus.aid;
    assign obi_bus.gnt    = obi_gnt;
    assign obi_bus.rvalid = obi_rvalid;
    assign obi_bus.rid    = obi_rid;
    assign obi_bus.rdata  = obi_rdata;

    vld_decode decode_i (
        .clk          (clk),
        .rstn         (rstn),
        .insn_valid   (insn_valid),
        .insn_ready   (insn_ready),
        .insn         (insn),
        .insn_rs1     (insn_rs1),
        .insn_err     (insn_err),
        .xadac        (xadac_bus.mst),
        .alloc_valid  (alloc_valid),
        .alloc_id     (alloc_id),
        .alloc_vd     (alloc_vd),
        .retire_valid (retire_valid),
        .retire_id    (retire_id)
    );

    xadac_vload_unit vload_i (
        .clk  (clk),
        .rstn (rstn),
        .slv  (xadac_bus.slv),
        .obi  (obi_bus.mst)
    );

    vld_reorder reorder_i (
        .clk          (clk),
        .rstn         (rstn),
        .xadac        (xadac_bus.mst),
        .alloc_valid  (alloc_valid),
        .alloc_id     (alloc_id),
        .alloc_vd     (alloc_vd),
        .retire_valid (retire_valid),
        .retire_id    (retire_id),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_vd        (wb_vd),
        .wb_data      (wb_data)
    );

endmodule

// File: design/xadac_if.sv
`timescale 1ns/10ps

interface xadac_if
    import vld_pkg::*;
();

    // Request channel, decode to load unit
    logic   req_valid;
    logic   req_ready;
    IdT     req_id;
    AddrT   req_rs1;
    ImmT    req_imm;

    // Response channel, load unit back towards the core side
    logic   resp_valid;
    logic   resp_ready;
    IdT     resp_id;
    VectorT resp_vd;
    AddrT   resp_rd;

    modport mst (
        output req_valid, req_id, req_rs1, req_imm,
        input  req_ready,
        input  resp_valid, resp_id, resp_vd, resp_rd,
        output resp_ready
    );

    modport slv (
        input  req_valid, req_id, req_rs1, req_imm,
        output req_ready,
        output resp_valid, resp_id, resp_vd, resp_rd,
        input  resp_ready
    );

endinterface

// File: design/xadac_vload_unit.sv
`timescale 1ns/10ps

module xadac_vload_unit
    import vld_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    xadac_if.slv slv,
    obi_if.mst   obi
);

    // Scoreboard, one entry per ID
    logic [NoIds-1:0] req_done_q, req_done_d;
    logic [NoIds-1:0] a_done_q, a_done_d;
    logic [NoIds-1:0] r_done_q, r_done_d;
    AddrT             addr_q  [NoIds];
    AddrT             addr_d  [NoIds];
    ImmT              imm_q   [NoIds];
    ImmT              imm_d   [NoIds];
    VectorT           rdata_q [NoIds];
    VectorT           rdata_d [NoIds];

    logic   resp_valid_d;
    IdT     resp_id_d;
    VectorT resp_vd_d;
    logic   resp_free;

    logic   obi_req_d;
    AddrT   obi_addr_d;
    IdT     obi_aid_d;
    logic   obi_free;

    // Element i of the result takes memory element (i mod period)
    function automatic VectorT replicate(VectorT data, ImmT period);
        VectorT      res;
        int unsigned j;
        res = '0;
        for (int unsigned i = 0; i < NoElems; i++) begin
            j = i % period;
            res[ElemWidth*i +: ElemWidth] = data[ElemWidth*j +: ElemWidth];
        end
        return res;
    endfunction

    assign slv.resp_rd = '0;

    // Read-only master
    assign obi.we     = 1'b0;
    assign obi.be     = '0;
    assign obi.wdata  = '0;
    assign obi.rready = 1'b1;

    always_comb begin
        req_done_d   = req_done_q;
        a_done_d     = a_done_q;
        r_done_d     = r_done_q;
        addr_d       = addr_q;
        imm_d        = imm_q;
        rdata_d      = rdata_q;

        resp_valid_d = slv.resp_valid;
        resp_id_d    = slv.resp_id;
        resp_vd_d    = slv.resp_vd;

        obi_req_d    = obi.req;
        obi_addr_d   = obi.addr;
        obi_aid_d    = obi.aid;

        // Read data returns
        if (obi.rvalid && obi.rready) begin
            rdata_d[obi.rid]  = obi.rdata;
            r_done_d[obi.rid] = 1'b1;
        end

        // Address phase granted
        if (obi.req && obi.gnt) begin
            a_done_d[obi.aid] = 1'b1;
            obi_req_d         = 1'b0;
        end

        // Response taken, entry becomes free
        if (slv.resp_valid && slv.resp_ready) begin
            req_done_d[slv.resp_id] = 1'b0;
            a_done_d[slv.resp_id]   = 1'b0;
            r_done_d[slv.resp_id]   = 1'b0;
            resp_valid_d            = 1'b0;
        end

        slv.req_ready = slv.req_valid && !req_done_d[slv.req_id];

        if (slv.req_valid && slv.req_ready) begin
            addr_d[slv.req_id]     = slv.req_rs1;
            imm_d[slv.req_id]      = slv.req_imm;
            req_done_d[slv.req_id] = 1'b1;
        end

        // Next read to issue, highest ID wins
        obi_free = !obi_req_d;
        for (int unsigned id = 0; id < NoIds; id++) begin
            if (obi_free && req_done_d[id] && !a_done_d[id]) begin
                obi_req_d  = 1'b1;
                obi_addr_d = addr_d[id];
                obi_aid_d  = IdT'(id);
            end
        end

        // Next response, highest ID wins
        resp_free = !resp_valid_d;
        for (int unsigned id = 0; id < NoIds; id++) begin
            if (resp_free && r_done_d[id]) begin
                resp_valid_d = 1'b1;
                resp_id_d    = IdT'(id);
                resp_vd_d    = replicate(rdata_d[id], imm_d[id]);
            end
        end
    end

    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) begin
            req_done_q     <= '0;
            a_done_q       <= '0;
            r_done_q       <= '0;
            slv.resp_valid <= 1'b0;
            obi.req        <= 1'b0;
        end else begin
            req_done_q     <= req_done_d;
            a_done_q       <= a_done_d;
            r_done_q       <= r_done_d;
            slv.resp_valid <= resp_valid_d;
            obi.req        <= obi_req_d;
        end
    end

    always_ff @(posedge clk) begin
        addr_q      <= addr_d;
        imm_q       <= imm_d;
        rdata_q     <= rdata_d;
        slv.resp_id <= resp_id_d;
        slv.resp_vd <= resp_vd_d;
        obi.addr    <= obi_addr_d;
        obi.aid     <= obi_aid_d;
    end

    // Memory must only answer reads whose address phase was granted
    a_rvalid_granted: assert property (
        @(posedge clk) disable iff (!rstn) obi.rvalid |-> a_done_q[obi.rid]
    ) else $error("rvalid for ID %0d without granted request", obi.rid);

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        obi.req && !obi.gnt |=> obi.req && $stable(obi.addr) && $stable(obi.aid)
    ) else $error("OBI request changed before grant");

endmodule

// File: tb/vld_tb.sv
`timescale 1ns/10ps

module vld_tb
    import vld_pkg::*;
();

    localparam int unsigned MemWords  = 16;
    localparam int unsigned DataWords = 256;
    localparam int unsigned MaxRecs   = (DataWords - MemWords) / 4;
    localparam VregT        BadVd     = 5'd31;

    logic   clk        = 1'b0;
    logic   rstn       = 1'b0;
    logic   insn_valid = 1'b0;
    logic   insn_ready;
    InsnT   insn       = '0;
    AddrT   insn_rs1   = '0;
    logic   insn_err;
    logic   obi_req;
    logic   obi_gnt    = 1'b0;
    AddrT   obi_addr;
    IdT     obi_aid;
    logic   obi_rvalid = 1'b0;
    IdT     obi_rid    = '0;
    VectorT obi_rdata  = '0;
    logic   wb_valid;
    logic   wb_ready   = 1'b0;
    VregT   wb_vd;
    VectorT wb_data;

    // Memory image followed by records of insn, rs1, vd, data
    logic [127:0] tdata [DataWords];
    logic         loaded = 1'b0;
    int           n_recs = 0;
    int           errors = 0;
    int           test_errors = 0;
    int           n_checks = 0;
    int           n_tests = 0;
    int           wb_count = 0;
    int           exp_total = 0;

    // Expected writebacks in issue order
    VregT         exp_vd_q[$];
    VectorT       exp_data_q[$];
    int           exp_rec_q[$];
    VregT         mon_vd;
    VectorT       mon_data;
    int           mon_rec;

    // Memory model state
    logic [15:0]  lfsr_state = 16'd47477;
    IdT           rd_id_q[$];
    AddrT         rd_addr_q[$];
    AddrT         rd_addr;
    int           gnt_wait = 0;
    int           r_wait = 0;

    vld_top vld_top_i (.*);

    always #20 clk = ~clk;

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int random_bits(int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic logic [7:0] rec_base(int r);
        return 8'(MemWords + 4 * r);
    endfunction

    task automatic compare(string name, VectorT expected, VectorT actual);
        n_checks++;
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        n_tests++;
        $display("%s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // Offer one record and wait until decode takes it
    task automatic send_record(int r);
        InsnT i_word;
        AddrT i_rs1;
        VregT e_vd;
        logic bad;
        i_word = InsnT'(tdata[rec_base(r)]);
        i_rs1  = AddrT'(tdata[rec_base(r) + 8'd1]);
        e_vd   = VregT'(tdata[rec_base(r) + 8'd2]);
        bad    = (e_vd == BadVd);
        insn_valid <= 1'b1;
        insn       <= i_word;
        insn_rs1   <= i_rs1;
        @(posedge clk);
        while (!insn_ready) @(posedge clk);
        insn_valid <= 1'b0;
        if (!bad) begin
            exp_vd_q.push_back(e_vd);
            exp_data_q.push_back(tdata[rec_base(r) + 8'd3]);
            exp_rec_q.push_back(r);
            exp_total++;
        end
        @(posedge clk);
        compare($sformatf("rec%0d insn_err", r), VectorT'(bad), VectorT'(insn_err));
    endtask

    task automatic wait_drained();
        while (exp_vd_q.size() != 0) @(posedge clk);
    endtask

    // OBI slave with random grant and read latency
    always @(posedge clk) begin
        if (!rstn) begin
            obi_gnt    <= 1'b0;
            obi_rvalid <= 1'b0;
        end else begin
            if (obi_req && obi_gnt) begin
                rd_id_q.push_back(obi_aid);
                rd_addr_q.push_back(obi_addr);
                obi_gnt <= 1'b0;
                gnt_wait = random_bits(2);
            end else if (obi_req) begin
                if (gnt_wait == 0) obi_gnt <= 1'b1;
                else gnt_wait--;
            end
            // Reads return in grant order
            obi_rvalid <= 1'b0;
            if (rd_id_q.size() != 0) begin
                if (r_wait == 0) begin
                    rd_addr = rd_addr_q.pop_front();
                    obi_rvalid <= 1'b1;
                    obi_rid    <= rd_id_q.pop_front();
                    obi_rdata  <= tdata[{4'h0, rd_addr[7:4]}];
                    r_wait = random_bits(2);
                end else begin
                    r_wait--;
                end
            end
        end
    end

    // Writeback checker
    always @(posedge clk) begin
        if (rstn && wb_valid && wb_ready) begin
            wb_count++;
            if (exp_vd_q.size() == 0) begin
                $display("Writeback to v%0d arrived while no load was outstanding", wb_vd);
                errors++;
                test_errors++;
            end else begin
                mon_vd   = exp_vd_q.pop_front();
                mon_data = exp_data_q.pop_front();
                mon_rec  = exp_rec_q.pop_front();
                compare($sformatf("rec%0d vd", mon_rec), VectorT'(mon_vd), VectorT'(wb_vd));
                compare($sformatf("rec%0d data", mon_rec), mon_data, wb_data);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_recs * 40 + 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", n_recs * 40 + 200);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int r;
        int accepted;
        foreach (tdata[w]) tdata[w] = '1;
        $readmemh("tb/vld_testdata.hex", tdata);
        while (n_recs < MaxRecs && tdata[rec_base(n_recs)] != '1) n_recs++;
        loaded = 1'b1;
        if (n_recs == 0) begin
            $display("Data file holds no instruction records");
            errors++;
        end

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        compare("reset wb_valid", '0, VectorT'(wb_valid));
        compare("reset obi_req", '0, VectorT'(obi_req));
        compare("reset insn_err", '0, VectorT'(insn_err));
        finish_test("reset");

        // One load at a time
        wb_ready <= 1'b1;
        for (int i = 0; i < n_recs; i++) begin
            send_record(i);
            wait_drained();
        end
        finish_test("single_loads");

        for (int i = 0; i < n_recs; i++) send_record(i);
        wait_drained();
        finish_test("back_to_back");

        // Fill all four IDs while writeback is blocked
        wb_ready <= 1'b0;
        accepted = 0;
        r = 0;
        while (accepted < int'(NoIds) && r < n_recs) begin
            if (VregT'(tdata[rec_base(r) + 8'd2]) != BadVd) begin
                send_record(r);
                accepted++;
            end
            r++;
        end
        while (!wb_valid) @(posedge clk);
        // Oldest result has to stay on the port while wb_ready is low
        repeat (4) @(posedge clk);
        compare("backpressure insn_ready", '0, VectorT'(insn_ready));
        compare("backpressure wb_valid", VectorT'(1'b1), VectorT'(wb_valid));
        compare("backpressure head vd", VectorT'(exp_vd_q[0]), VectorT'(wb_vd));
        compare("backpressure head data", exp_data_q[0], wb_data);
        wb_ready <= 1'b1;
        while (r < n_recs) begin
            send_record(r);
            r++;
        end
        wait_drained();
        finish_test("backpressure");

        compare("total writebacks", VectorT'(exp_total), VectorT'(wb_count));
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/vld_testdata.hex
// Lines 1 to 16: memory image, one 128-bit vector per line, element 7 leftmost
// Then one record per line: insn rs1 vd data, vd 1F marks an illegal instruction
00070006000500040003000200010000
11071106110511041103110211011100
22072206220522042203220222012200
33073306330533043303330233013300
44074406440544044403440244014400
55075506550555045503550255015500
66076606660566046603660266016600
77077706770577047703770277017700
88078806880588048803880288018800
99079906990599049903990299019900
AA07AA06AA05AA04AA03AA02AA01AA00
BB07BB06BB05BB04BB03BB02BB01BB00
CC07CC06CC05CC04CC03CC02CC01CC00
DD07DD06DD05DD04DD03DD02DD01DD00
EE07EE06EE05EE04EE03EE02EE01EE00
FF07FF06FF05FF04FF03FF02FF01FF00
0080008B 00000010 01 11071106110511041103110211011100
0010010B 00000020 02 22002200220022002200220022002200
0020018B 00000030 03 33013300330133003301330033013300
0030020B 00000040 04 44014400440244014400440244014400
0050028B 00000050 05 55025501550055045503550255015500
00800087 00000000 1F 00000000000000000000000000000000
0000030B 00000060 1F 00000000000000000000000000000000
0090038B 00000070 1F 00000000000000000000000000000000
0080108B 00000080 1F 00000000000000000000000000000000
0070040B 000000F0 08 FF00FF06FF05FF04FF03FF02FF01FF00
0040048B 000000A0 09 AA03AA02AA01AA00AA03AA02AA01AA00

// File: vld.f
design/vld_pkg.sv
design/xadac_if.sv
design/obi_if.sv
design/vld_decode.sv
design/xadac_vload_unit.sv
design/vld_reorder.sv
design/vld_top.sv
tb/vld_tb.sv
